// ==== sources.f ====
+incdir+verilog
verilog/ram_op_pkg.sv
verilog/ram_geom_pkg.sv
verilog/port_decoder.sv
verilog/write_arbiter.sv
verilog/ram_array.sv
verilog/read_return.sv
verilog/dual_port_ram_top.sv
test/ram_chk.sv
test/ram_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module ram_tb -f sources.f -o ram_sim \
	&& out=$(./obj_dir/ram_sim; true) \
	&& echo "$out" \
	&& echo "$out" | grep -q "All tests passed" \
	&& echo "simulation PASSED" \
	|| { echo "simulation FAILED"; exit 1; }

// ==== test/ram_tb.sv ====
`timescale 1ns/100ps
`include "ram_params.svh"

module ram_tb;

	localparam int AW          = `RAM_ADDR_W;
	localparam int BW          = `RAM_B_ADDR_W;
	localparam int WW          = `RAM_WORD_W;
	localparam int LW          = `RAM_LANE_W;
	localparam int MAX_ROWS    = 256;
	localparam int RST_TIMEOUT = 50;   // cycles
	localparam int RAND_ROWS   = 200;

	typedef struct packed {
		logic          rce_a;
		logic [AW-1:0] ra_a;
		logic          wce_a;
		logic [AW-1:0] wa_a;
		logic [WW-1:0] wd_a;
		logic          rce_b;
		logic [BW-1:0] ra_b;
		logic          wce_b;
		logic [BW-1:0] wa_b;
		logic [LW-1:0] wd_b;
		logic [WW-1:0] exp_a;   // rq_a once this row is taken
		logic [LW-1:0] exp_b;
	} row_t;

	logic          clk;
	logic          rst;
	logic          rce_a;
	logic [AW-1:0] ra_a;
	logic [WW-1:0] rq_a;
	logic          wce_a;
	logic [AW-1:0] wa_a;
	logic [WW-1:0] wd_a;
	logic          rce_b;
	logic [BW-1:0] ra_b;
	logic [LW-1:0] rq_b;
	logic          wce_b;
	logic [BW-1:0] wa_b;
	logic [LW-1:0] wd_b;

	row_t          rows [0:MAX_ROWS-1];
	int            n_rows = 0;
	integer        seed   = 99;
	logic [WW-1:0] model_mem [0:`RAM_DEPTH-1];

	dual_port_ram_top dut0 (
		.clk   (clk),
		.rst   (rst),
		.rce_a (rce_a),
		.ra_a  (ra_a),
		.rq_a  (rq_a),
		.wce_a (wce_a),
		.wa_a  (wa_a),
		.wd_a  (wd_a),
		.rce_b (rce_b),
		.ra_b  (ra_b),
		.rq_b  (rq_b),
		.wce_b (wce_b),
		.wa_b  (wa_b),
		.wd_b  (wd_b)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// table building
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic add_row(
		input logic          r_ce_a,
		input logic [AW-1:0] r_a,
		input logic          w_ce_a,
		input logic [AW-1:0] w_a,
		input logic [WW-1:0] d_a,
		input logic          r_ce_b,
		input logic [BW-1:0] r_b,
		input logic          w_ce_b,
		input logic [BW-1:0] w_b,
		input logic [LW-1:0] d_b
	);
		row_t row;
		row       = '0;
		row.rce_a = r_ce_a;
		row.ra_a  = r_a;
		row.wce_a = w_ce_a;
		row.wa_a  = w_a;
		row.wd_a  = d_a;
		row.rce_b = r_ce_b;
		row.ra_b  = r_b;
		row.wce_b = w_ce_b;
		row.wa_b  = w_b;
		row.wd_b  = d_b;
		rows[n_rows] = row;
		n_rows++;
	endtask

	function automatic logic [WW-1:0] rand_word();
		logic [63:0] r;
		r = {$random(seed), $random(seed)};
		return r[WW-1:0];
	endfunction

	function automatic logic [LW-1:0] rand_lane();
		logic [31:0] r;
		r = $random(seed);
		return r[LW-1:0];
	endfunction

	// reference model reads first and lets port a write last
	task automatic predict_responses();
		logic [WW-1:0] q_a;
		logic [LW-1:0] q_b;
		logic [WW-1:0] word;
		q_a = '0;
		q_b = '0;
		for (int i = 0; i < n_rows; i++) begin
			if (rows[i].rce_a)
				q_a = model_mem[rows[i].ra_a];
			if (rows[i].rce_b) begin
				word = model_mem[rows[i].ra_b[BW-1:1]];
				q_b  = rows[i].ra_b[0] ? word[WW-1:LW] : word[LW-1:0];   // lane 0 is low half
			end
			if (rows[i].wce_b) begin
				if (rows[i].wa_b[0])
					model_mem[rows[i].wa_b[BW-1:1]][WW-1:LW] = rows[i].wd_b;
				else
					model_mem[rows[i].wa_b[BW-1:1]][LW-1:0] = rows[i].wd_b;
			end
			if (rows[i].wce_a)
				model_mem[rows[i].wa_a] = rows[i].wd_a;
			rows[i].exp_a = q_a;
			rows[i].exp_b = q_b;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// driving and checking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic drive_row(input row_t row);
		rce_a <= row.rce_a;
		ra_a  <= row.ra_a;
		wce_a <= row.wce_a;
		wa_a  <= row.wa_a;
		wd_a  <= row.wd_a;
		rce_b <= row.rce_b;
		ra_b  <= row.ra_b;
		wce_b <= row.wce_b;
		wa_b  <= row.wa_b;
		wd_b  <= row.wd_b;
	endtask

	task automatic compare_rq(
		input string         name,
		input logic [WW-1:0] got,
		input logic [WW-1:0] exp,
		input int            row
	);
		assert (got === exp) else begin
			$display("CHECK FAILED %s after row %0d: expected %h, got %h", name, row, exp, got);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic check_bound_asserts(input int row);
		assert (dut0.u_chk.fail_count == 0) else begin
			$display("a bound assertion on the read outputs failed by row %0d", row);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (rst === 1'b1 && cycles < RST_TIMEOUT);
		if (rst === 1'b1) begin
			$display("reset still asserted after %0d cycles", RST_TIMEOUT);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	initial begin : stim
		logic [31:0]   r;
		logic [WW-1:0] exp_a_prev;
		logic [LW-1:0] exp_b_prev;
		drive_row('0);

		add_row(1'b0, 10'd0, 1'b0, 10'd0, 36'h0, 1'b0, 11'd0, 1'b0, 11'd0, 18'h0);  // zero after reset
		add_row(1'b0, 10'd0, 1'b0, 10'd0, 36'h0, 1'b0, 11'd0, 1'b0, 11'd0, 18'h0);
		for (int k = 0; k < 8; k++)   // words 0..7 get known contents
			add_row(1'b0, 10'd0, 1'b1, AW'(k), rand_word(), 1'b0, 11'd0, 1'b0, 11'd0, 18'h0);
		// word write and read on port a followed by a hold row
		add_row(1'b0, 10'd0, 1'b1, 10'd3, 36'h1_2345_6789, 1'b0, 11'd0, 1'b0, 11'd0, 18'h0);
		add_row(1'b1, 10'd3, 1'b0, 10'd0, 36'h0, 1'b0, 11'd0, 1'b0, 11'd0, 18'h0);
		add_row(1'b0, 10'd0, 1'b0, 10'd0, 36'h0, 1'b0, 11'd0, 1'b0, 11'd0, 18'h0);
		// halves written on b and read as words on a and the reverse
		add_row(1'b0, 10'd0, 1'b0, 10'd0, 36'h0, 1'b0, 11'd0, 1'b1, 11'd10, 18'h2AAAA);
		add_row(1'b0, 10'd0, 1'b0, 10'd0, 36'h0, 1'b0, 11'd0, 1'b1, 11'd11, 18'h15555);
		add_row(1'b1, 10'd5, 1'b0, 10'd0, 36'h0, 1'b0, 11'd0, 1'b0, 11'd0, 18'h0);
		add_row(1'b0, 10'd0, 1'b1, 10'd6, 36'hA_BCDE_1234, 1'b0, 11'd0, 1'b0, 11'd0, 18'h0);
		add_row(1'b0, 10'd0, 1'b0, 10'd0, 36'h0, 1'b1, 11'd12, 1'b0, 11'd0, 18'h0);
		add_row(1'b0, 10'd0, 1'b0, 10'd0, 36'h0, 1'b1, 11'd13, 1'b0, 11'd0, 18'h0);
		// read-first on both ports
		add_row(1'b1, 10'd2, 1'b1, 10'd2, 36'h0_FACE_CAFE, 1'b1, 11'd4, 1'b1, 11'd4, 18'h3_0303);
		add_row(1'b1, 10'd2, 1'b0, 10'd0, 36'h0, 1'b1, 11'd4, 1'b0, 11'd0, 18'h0);
		// same lane collision followed by writes to different words
		add_row(1'b0, 10'd0, 1'b1, 10'd7, 36'h7_7777_7777, 1'b0, 11'd0, 1'b1, 11'd14, 18'h0_1111);
		add_row(1'b1, 10'd7, 1'b0, 10'd0, 36'h0, 1'b1, 11'd14, 1'b0, 11'd0, 18'h0);
		add_row(1'b0, 10'd0, 1'b1, 10'd4, 36'h4_4444_4444, 1'b0, 11'd0, 1'b1, 11'd3, 18'h2_2222);
		add_row(1'b1, 10'd4, 1'b0, 10'd0, 36'h0, 1'b1, 11'd3, 1'b0, 11'd0, 18'h0);
		add_row(1'b1, 10'd1, 1'b0, 10'd0, 36'h0, 1'b0, 11'd0, 1'b0, 11'd0, 18'h0);
		add_row(1'b0, 10'd0, 1'b0, 10'd0, 36'h0, 1'b0, 11'd0, 1'b0, 11'd0, 18'h0);
		add_row(1'b0, 10'd0, 1'b0, 10'd0, 36'h0, 1'b0, 11'd0, 1'b0, 11'd0, 18'h0);
		// random traffic kept inside the filled words
		for (int k = 0; k < RAND_ROWS; k++) begin
			r = $random(seed);
			add_row(r[0], AW'(r[3:1]), r[4], AW'(r[7:5]), rand_word(),
				r[8], BW'(r[12:9]), r[13], BW'(r[17:14]), rand_lane());
		end
		predict_responses();

		wait_reset_release();
		exp_a_prev = '0;
		exp_b_prev = '0;
		for (int i = 0; i <= n_rows; i++) begin
			@(posedge clk);
			if (i < n_rows)
				drive_row(rows[i]);
			else
				drive_row('0);
			@(negedge clk);   // previous row was taken at the edge just past
			compare_rq("rq_a", rq_a, exp_a_prev, i - 1);
			compare_rq("rq_b", {{(WW-LW){1'b0}}, rq_b}, {{(WW-LW){1'b0}}, exp_b_prev}, i - 1);
			check_bound_asserts(i - 1);
			if (i < n_rows) begin
				exp_a_prev = rows[i].exp_a;
				exp_b_prev = rows[i].exp_b;
			end
		end

		$display("All tests passed");
		$finish;
	end

endmodule

// ==== test/ram_chk.sv ====
`timescale 1ns/100ps
`include "ram_params.svh"

module ram_chk (
	input logic                    clk,
	input logic                    rst,
	input logic                    rce_a,
	input logic                    rce_b,
	input logic [`RAM_WORD_W-1:0]  rq_a,
	input logic [`RAM_LANE_W-1:0]  rq_b
);

	int fail_count = 0;   // failed assertions so far

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read outputs come out of reset cleared
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	rq_a_reset: assert property (@(posedge clk) rst |=> (rq_a == '0))
		else begin
			fail_count++;
			$error("rq_a not zero after reset");
		end
	rq_b_reset: assert property (@(posedge clk) rst |=> (rq_b == '0))
		else begin
			fail_count++;
			$error("rq_b not zero after reset");
		end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// hold between reads
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	rq_a_hold: assert property (@(posedge clk) (!rst && !rce_a) |=> $stable(rq_a))
		else begin
			fail_count++;
			$error("rq_a changed without a read");
		end
	rq_b_hold: assert property (@(posedge clk) (!rst && !rce_b) |=> $stable(rq_b))
		else begin
			fail_count++;
			$error("rq_b changed without a read");
		end

	// returned data is always known
	rq_a_known: assert property (@(posedge clk) (!rst && rce_a) |=> !$isunknown(rq_a))
		else begin
			fail_count++;
			$error("rq_a has unknown bits after a read");
		end
	rq_b_known: assert property (@(posedge clk) (!rst && rce_b) |=> !$isunknown(rq_b))
		else begin
			fail_count++;
			$error("rq_b has unknown bits after a read");
		end

endmodule

bind dual_port_ram_top ram_chk u_chk (
	.clk   (clk),
	.rst   (rst),
	.rce_a (rce_a),
	.rce_b (rce_b),
	.rq_a  (rq_a),
	.rq_b  (rq_b)
);

// ==== verilog/dual_port_ram_top.sv ====
`timescale 1ns/100ps
`include "ram_params.svh"

module dual_port_ram_top (
	input  logic                      clk,
	input  logic                      rst,
	// port a, full word
	input  logic                      rce_a,
	input  logic [`RAM_ADDR_W-1:0]    ra_a,
	output logic [`RAM_WORD_W-1:0]    rq_a,
	input  logic                      wce_a,
	input  logic [`RAM_ADDR_W-1:0]    wa_a,
	input  logic [`RAM_WORD_W-1:0]    wd_a,
	// port b, half word
	input  logic                      rce_b,
	input  logic [`RAM_B_ADDR_W-1:0]  ra_b,
	output logic [`RAM_LANE_W-1:0]    rq_b,
	input  logic                      wce_b,
	input  logic [`RAM_B_ADDR_W-1:0]  wa_b,
	input  logic [`RAM_LANE_W-1:0]    wd_b
);

	import ram_op_pkg::*;
	import ram_geom_pkg::*;

	ram_op_t                 op_a;
	ram_op_t                 op_b;
	logic                    re_a;
	logic                    re_b;
	word_addr_t              rd_word_a;
	word_addr_t              rd_word_b;
	lane_sel_t               rd_lane_a;
	lane_sel_t               rd_lane_b;
	word_addr_t              wr_word_a;
	word_addr_t              wr_word_b;
	lane_mask_t              wr_mask_a;
	lane_mask_t              wr_mask_b;
	logic [`RAM_WORD_W-1:0]  wr_data_a;
	logic [`RAM_WORD_W-1:0]  wr_data_b;
	lane_mask_t              we_a;
	lane_mask_t              we_b;
	logic [`RAM_WORD_W-1:0]  rd_data_a;
	logic [`RAM_WORD_W-1:0]  rd_data_b;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	port_decoder #(
		.ADDR_W           (`RAM_ADDR_W),
		.LANES_PER_ACCESS (`RAM_LANES)
	) u_dec_a (
		.rce     (rce_a),
		.ra      (ra_a),
		.wce     (wce_a),
		.wa      (wa_a),
		.wd      (wd_a),
		.op      (op_a),
		.rd_en   (re_a),
		.rd_word (rd_word_a),
		.rd_lane (rd_lane_a),
		.wr_word (wr_word_a),
		.wr_mask (wr_mask_a),
		.wr_data (wr_data_a)
	);

	port_decoder #(
		.ADDR_W           (`RAM_B_ADDR_W),
		.LANES_PER_ACCESS (1)
	) u_dec_b (
		.rce     (rce_b),
		.ra      (ra_b),
		.wce     (wce_b),
		.wa      (wa_b),
		.wd      (wd_b),
		.op      (op_b),
		.rd_en   (re_b),
		.rd_word (rd_word_b),
		.rd_lane (rd_lane_b),
		.wr_word (wr_word_b),
		.wr_mask (wr_mask_b),
		.wr_data (wr_data_b)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// arbitration and storage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	write_arbiter u_arb (
		.op_a      (op_a),
		.wr_word_a (wr_word_a),
		.wr_mask_a (wr_mask_a),
		.op_b      (op_b),
		.wr_word_b (wr_word_b),
		.wr_mask_b (wr_mask_b),
		.we_a      (we_a),
		.we_b      (we_b)
	);

	ram_array u_mem (
		.clk       (clk),
		.we_a      (we_a),
		.wr_word_a (wr_word_a),
		.wr_data_a (wr_data_a),
		.we_b      (we_b),
		.wr_word_b (wr_word_b),
		.wr_data_b (wr_data_b),
		.re_a      (re_a),
		.rd_word_a (rd_word_a),
		.re_b      (re_b),
		.rd_word_b (rd_word_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read return
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	read_return #(.OUT_W(`RAM_WORD_W)) u_ret_a (
		.clk     (clk),
		.rst     (rst),
		.re      (re_a),
		.rd_lane (rd_lane_a),
		.rd_data (rd_data_a),
		.rq      (rq_a)
	);

	read_return #(.OUT_W(`RAM_LANE_W)) u_ret_b (
		.clk     (clk),
		.rst     (rst),
		.re      (re_b),
		.rd_lane (rd_lane_b),
		.rd_data (rd_data_b),
		.rq      (rq_b)
	);

endmodule

// ==== verilog/read_return.sv ====
`timescale 1ns/100ps
`include "ram_params.svh"

module read_return #(
	parameter int OUT_W = `RAM_WORD_W
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     re,
	input  ram_geom_pkg::lane_sel_t  rd_lane,
	input  logic [`RAM_WORD_W-1:0]   rd_data,
	output logic [OUT_W-1:0]         rq
);

	import ram_geom_pkg::*;

	logic             re_q;      // array output is fresh this cycle
	lane_sel_t        lane_q;    // lags with the array read
	logic [OUT_W-1:0] sel_data;
	logic [OUT_W-1:0] rq_hold;

	always_ff @(posedge clk) begin
		if (rst) begin
			re_q    <= 1'b0;
			rq_hold <= '0;
		end else begin
			re_q    <= re;
			rq_hold <= rq;
		end
		lane_q <= rd_lane;
	end

	generate
		if (OUT_W == `RAM_WORD_W) begin : g_word
			assign sel_data = rd_data;
		end else begin : g_lane
			assign sel_data = lane_of(rd_data, int'(lane_q));
		end
	endgenerate

	// new data right after a read, last value otherwise
	assign rq = re_q ? sel_data : rq_hold;

endmodule

// ==== verilog/ram_array.sv ====
`timescale 1ns/100ps
`include "ram_params.svh"

module ram_array (
	input  logic                      clk,
	input  ram_geom_pkg::lane_mask_t  we_a,
	input  ram_geom_pkg::word_addr_t  wr_word_a,
	input  logic [`RAM_WORD_W-1:0]    wr_data_a,
	input  ram_geom_pkg::lane_mask_t  we_b,
	input  ram_geom_pkg::word_addr_t  wr_word_b,
	input  logic [`RAM_WORD_W-1:0]    wr_data_b,
	input  logic                      re_a,
	input  ram_geom_pkg::word_addr_t  rd_word_a,
	input  logic                      re_b,
	input  ram_geom_pkg::word_addr_t  rd_word_b,
	output logic [`RAM_WORD_W-1:0]    rd_data_a,
	output logic [`RAM_WORD_W-1:0]    rd_data_b
);

	import ram_geom_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// one memory per lane
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	genvar l;
	generate
		for (l = 0; l < `RAM_LANES; l++) begin : g_lane
			lane_data_t mem [`RAM_DEPTH];
			lane_data_t q_a;
			lane_data_t q_b;

			// b first so a overwrites on a collision
			always_ff @(posedge clk) begin
				if (we_b[l])
					mem[wr_word_b] <= lane_of(wr_data_b, l);
				if (we_a[l])
					mem[wr_word_a] <= lane_of(wr_data_a, l);
			end

			// nonblocking read sees the pre-write word
			always_ff @(posedge clk) begin
				if (re_a)
					q_a <= mem[rd_word_a];
				if (re_b)
					q_b <= mem[rd_word_b];
			end

			assign rd_data_a[l*`RAM_LANE_W +: `RAM_LANE_W] = q_a;
			assign rd_data_b[l*`RAM_LANE_W +: `RAM_LANE_W] = q_b;
		end
	endgenerate

endmodule

// ==== verilog/write_arbiter.sv ====
`timescale 1ns/100ps

module write_arbiter (
	input  ram_op_pkg::ram_op_t       op_a,
	input  ram_geom_pkg::word_addr_t  wr_word_a,
	input  ram_geom_pkg::lane_mask_t  wr_mask_a,
	input  ram_op_pkg::ram_op_t       op_b,
	input  ram_geom_pkg::word_addr_t  wr_word_b,
	input  ram_geom_pkg::lane_mask_t  wr_mask_b,
	output ram_geom_pkg::lane_mask_t  we_a,
	output ram_geom_pkg::lane_mask_t  we_b
);

	import ram_op_pkg::*;
	import ram_geom_pkg::*;

	lane_mask_t act_a;
	lane_mask_t act_b;
	lane_mask_t overlap;
	logic       same_word;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// qualify masks with the write opcode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		act_a = '0;
		act_b = '0;
		if (op_writes(op_a))
			act_a = wr_mask_a;
		if (op_writes(op_b))
			act_b = wr_mask_b;
	end

	assign same_word = (wr_word_a == wr_word_b);

	// lanes both ports want in the same word
	assign overlap = same_word ? (act_a & act_b) : '0;

	// port a has priority, b keeps only the lanes a leaves alone
	assign we_a = act_a;
	assign we_b = act_b & ~overlap;

endmodule

// ==== verilog/port_decoder.sv ====
`timescale 1ns/100ps
`include "ram_params.svh"

module port_decoder #(
	parameter int ADDR_W           = `RAM_ADDR_W,
	parameter int LANES_PER_ACCESS = `RAM_LANES
) (
	input  logic                                 rce,
	input  logic [ADDR_W-1:0]                    ra,
	input  logic                                 wce,
	input  logic [ADDR_W-1:0]                    wa,
	input  logic [LANES_PER_ACCESS*`RAM_LANE_W-1:0] wd,
	output ram_op_pkg::ram_op_t                  op,
	output logic                                 rd_en,
	output ram_geom_pkg::word_addr_t             rd_word,
	output ram_geom_pkg::lane_sel_t              rd_lane,
	output ram_geom_pkg::word_addr_t             wr_word,
	output ram_geom_pkg::lane_mask_t             wr_mask,
	output logic [`RAM_WORD_W-1:0]               wr_data
);

	import ram_op_pkg::*;
	import ram_geom_pkg::*;

	localparam int SEL_W = $clog2(`RAM_LANES);

	assign op    = ram_op_t'({wce, rce});
	assign rd_en = op_reads(op);

	generate
		if (LANES_PER_ACCESS == `RAM_LANES) begin : g_wide
			// word port, address is the word index
			assign rd_word = ra;
			assign rd_lane = '0;           // whole word returned
			assign wr_word = wa;
			assign wr_mask = LANE_ALL;
			assign wr_data = wd;
		end else begin : g_narrow
			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			// half-word port: low bits pick the lane
			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			assign rd_word = ra[ADDR_W-1 -: `RAM_ADDR_W];
			assign rd_lane = lane_sel_t'(ra[SEL_W-1:0]);
			assign wr_word = wa[ADDR_W-1 -: `RAM_ADDR_W];
			assign wr_mask = lane_mask_t'(1) << wa[SEL_W-1:0];  // one-hot
			assign wr_data = {(`RAM_LANES / LANES_PER_ACCESS){wd}};  // same data on every lane
		end
	endgenerate

endmodule

// ==== verilog/ram_geom_pkg.sv ====
`include "ram_params.svh"

package ram_geom_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// word and lane types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [`RAM_ADDR_W-1:0]         word_addr_t;  // word index
	typedef logic [`RAM_LANES-1:0]          lane_mask_t;  // one bit per lane
	typedef logic [$clog2(`RAM_LANES)-1:0]  lane_sel_t;   // narrow read lane
	typedef logic [`RAM_LANE_W-1:0]         lane_data_t;

	// full-word access touches every lane
	localparam lane_mask_t LANE_ALL = '1;

	// lane 0 sits in the low bits of a word
	function automatic lane_data_t lane_of(
		input logic [`RAM_WORD_W-1:0] word,
		input int unsigned            lane
	);
		return word[lane*`RAM_LANE_W +: `RAM_LANE_W];
	endfunction

endpackage

// ==== verilog/ram_op_pkg.sv ====
`include "ram_params.svh"

package ram_op_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// access opcode, encoded as {wce, rce}
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [1:0] {
		op_idle       = 2'b00,
		op_read       = 2'b01,
		op_write      = 2'b10,
		op_read_write = 2'b11  // both channels in one cycle
	} ram_op_t;

	function automatic logic op_reads(input ram_op_t op);
		return op inside {op_read, op_read_write};
	endfunction

	function automatic logic op_writes(input ram_op_t op);
		return op inside {op_write, op_read_write};
	endfunction

endpackage

// ==== verilog/ram_params.svh ====
`ifndef RAM_PARAMS_SVH
`define RAM_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// storage geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define RAM_ADDR_W    10                           // word address, port a
`define RAM_DEPTH     1024                         // words in the array
`define RAM_LANE_W    18                           // one half-word lane
`define RAM_LANES     2
`define RAM_WORD_W    (`RAM_LANE_W * `RAM_LANES)   // 36
// port b addresses half-words, so one extra bit for the lane
`define RAM_B_ADDR_W  (`RAM_ADDR_W + $clog2(`RAM_LANES))

`endif
